// ==== dv/noncomp_patterns.txt ====
# opa      opb      fmt op tag result   status   (all hex, fmt 0 binary32 1 binary16)
# op 0 min 1 max 2 sgnj 3 sgnjn 4 sgnjx 5 feq 6 flt 7 fle, status 10 is NV
3f800000 40000000 0 0 0 3f800000 00
ffff3c00 ffffbc00 1 2 1 ffffbc00 00
3f800000 40000000 0 1 2 40000000 00
bf800000 c0000000 0 1 3 bf800000 00
00000000 80000000 0 0 4 80000000 00
80000000 00000000 0 1 5 00000000 00
7fc00000 40000000 0 0 6 40000000 00
3f800000 7fc12345 0 1 7 3f800000 00
7fc12345 7fc00000 0 0 8 7fc00000 00
7f800001 3f800000 0 1 9 3f800000 10
7f800001 7fc00000 0 0 a 7fc00000 10
3f800000 3f800000 0 3 b bf800000 00
bf800000 c0000000 0 4 c 3f800000 00
7f800001 80000000 0 2 d ff800001 00
ffff3c00 ffff4000 1 3 e ffffbc00 00
ffffbc00 ffffbc00 1 4 f ffff3c00 00
3f800000 3f800000 0 5 0 00000001 00
00000000 80000000 0 5 1 00000001 00
7fc00000 3f800000 0 5 2 00000000 00
7f800001 3f800000 0 5 3 00000000 10
bf800000 3f800000 0 6 4 00000001 00
7fc00000 3f800000 0 6 5 00000000 10
80000000 00000000 0 7 6 00000001 00
00000000 80000000 0 6 7 00000000 00
ffff3c00 ffff4000 1 6 8 00000001 00
00003c00 ffff3c00 1 5 9 00000000 00
00003c00 ffff3c00 1 7 a 00000000 10
00003c00 ffff4000 1 0 b ffff4000 00
ffff7c01 ffff3c00 1 1 c ffff3c00 10
ffff7e00 12345678 1 0 d ffff7e00 00
00003c00 ffffbc00 1 2 e fffffe00 00
ffff8000 ffff0000 1 0 f ffff8000 00

// ==== filelist.f ====
hdl/fpu_fmt_pkg.sv
hdl/fpu_op_pkg.sv
hdl/slice_out_if.sv
hdl/fpu_noncomp_slice.sv
hdl/fpu_result_arbiter.sv
hdl/fpu_noncomp_block.sv
dv/tb_fpu_noncomp_block.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it and judge the log

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f filelist.f \
  --top-module tb_fpu_noncomp_block -Mdir "$BUILD_DIR" -o sim
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/sim" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "Some tests failed" "$LOG"; then
  exit 1
fi
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi
exit 0

// ==== dv/tb_fpu_noncomp_block.sv ====
`timescale 1ns/1ps

/* Testbench for the non-computational FPU group: pattern file driver,
   tag-matched result checks, random back-pressure and a flush test */

module tb_fpu_noncomp_block;

  import fpu_fmt_pkg::*;
  import fpu_op_pkg::*;

  localparam int unsigned TagWidth   = 4;
  localparam int unsigned NumTags    = 1 << TagWidth;
  localparam int          HalfPeriod = 4;
  // Sample point 1 ns before the rising edge
  localparam int          SampleSkew = 3;
  localparam logic [31:0] LfsrSeed   = 32'h9e46_1726;
  // x^32 + x^22 + x^2 + x + 1
  localparam logic [31:0] LfsrTaps   = 32'h8020_0003;

  logic                clk_i;
  logic                rst_i;
  logic                flush_i;
  logic                in_valid_i;
  logic                in_ready_o;
  logic [1:0][31:0]    operands_i;
  operation_e          op_i;
  fp_format_e          fmt_i;
  logic [TagWidth-1:0] tag_i;
  logic                out_valid_o;
  logic                out_ready_i;
  logic [31:0]         result_o;
  status_t             status_o;
  logic [TagWidth-1:0] tag_o;
  logic                busy_o;

  // Pattern table
  logic [31:0]         pat_a   [$];
  logic [31:0]         pat_b   [$];
  logic                pat_fmt [$];
  logic [2:0]          pat_op  [$];
  logic [TagWidth-1:0] pat_tag [$];
  logic [31:0]         pat_res [$];
  logic [4:0]          pat_sts [$];
  int                  num_pat;
  int                  num_done;

  // Expected values of operations in flight by tag
  logic                pending [NumTags];
  logic [31:0]         exp_res [NumTags];
  logic [4:0]          exp_sts [NumTags];

  logic [31:0]         lfsr_q;
  logic                prev_stall;
  logic [31:0]         prev_result;
  logic [4:0]          prev_status;
  logic [TagWidth-1:0] prev_tag;

  fpu_noncomp_block DUT (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .flush_i     (flush_i),
    .in_valid_i  (in_valid_i),
    .in_ready_o  (in_ready_o),
    .operands_i  (operands_i),
    .op_i        (op_i),
    .fmt_i       (fmt_i),
    .tag_i       (tag_i),
    .out_valid_o (out_valid_o),
    .out_ready_i (out_ready_i),
    .result_o    (result_o),
    .status_o    (status_o),
    .tag_o       (tag_o),
    .busy_o      (busy_o)
  );

  initial clk_i = 1'b0;
  always #HalfPeriod clk_i = ~clk_i;

  // --------------------------------------------------------------------------
  // Helpers
  // --------------------------------------------------------------------------
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ LfsrTaps) : (s >> 1);
  endfunction

  task automatic draw_bits(input int n, output logic [31:0] bits);
    bits = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q  = lfsr_step(lfsr_q);
      bits[i] = lfsr_q[0];
    end
  endtask

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Some tests failed");
    $fatal(1, "Run stopped at %0t ns", $time);
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("CHECK FAILED at %0t ns: %s is 0x%h, expected 0x%h",
                          $time, name, got, exp));
    end
  endtask

  task automatic load_patterns();
    int          fd;
    int          n;
    string       line;
    logic [31:0] a, b, f, o, t, r, s;
    fd = $fopen("dv/noncomp_patterns.txt", "r");
    if (fd == 0) begin
      abort_run("Cannot open the pattern file dv/noncomp_patterns.txt");
    end
    while (!$feof(fd)) begin
      n = $fscanf(fd, "%h %h %h %h %h %h %h", a, b, f, o, t, r, s);
      if (n == 7) begin
        pat_a.push_back(a);
        pat_b.push_back(b);
        pat_fmt.push_back(f[0]);
        pat_op.push_back(o[2:0]);
        pat_tag.push_back(t[TagWidth-1:0]);
        pat_res.push_back(r);
        pat_sts.push_back(s[4:0]);
      end else if (n > 0) begin
        abort_run("A line of the pattern file has too few columns");
      end else begin
        // Comment line
        void'($fgets(line, fd));
      end
    end
    $fclose(fd);
    num_pat = pat_a.size();
  endtask

  task automatic drive_operation(input int i);
    in_valid_i    = 1'b1;
    operands_i[0] = pat_a[i];
    operands_i[1] = pat_b[i];
    fmt_i         = fp_format_e'(pat_fmt[i]);
    op_i          = operation_e'(pat_op[i]);
    tag_i         = pat_tag[i];
  endtask

  task automatic check_quiet();
    check_value("out_valid_o", 32'(out_valid_o), 32'd0);
    check_value("in_ready_o", 32'(in_ready_o), 32'd0);
    check_value("busy_o", 32'(busy_o), 32'd0);
  endtask

  // Called at the sample point of every cycle
  task automatic sample_output();
    int t;
    if (prev_stall) begin
      check_value("out_valid_o", 32'(out_valid_o), 32'd1);
      check_value("result_o", result_o, prev_result);
      check_value("status_o", {27'b0, status_o}, {27'b0, prev_status});
      check_value("tag_o", 32'(tag_o), 32'(prev_tag));
    end
    prev_stall  = out_valid_o && !out_ready_i && !flush_i;
    prev_result = result_o;
    prev_status = status_o;
    prev_tag    = tag_o;
    if (out_valid_o && out_ready_i) begin
      t = int'(tag_o);
      if (!pending[t]) begin
        abort_run($sformatf("Tag %0d came back at %0t ns with no operation in flight",
                            t, $time));
      end
      check_value("result_o", result_o, exp_res[t]);
      check_value("status_o", {27'b0, status_o}, {27'b0, exp_sts[t]});
      pending[t] = 1'b0;
      num_done++;
    end
  endtask

  // --------------------------------------------------------------------------
  // Stimulus and checking
  // --------------------------------------------------------------------------
  initial begin
    logic [31:0] bits;
    int          idx;
    logic        acc;
    rst_i       = 1'b1;
    flush_i     = 1'b0;
    in_valid_i  = 1'b0;
    operands_i  = '0;
    op_i        = OP_MIN;
    fmt_i       = FMT_FP32;
    tag_i       = '0;
    out_ready_i = 1'b0;
    lfsr_q      = LfsrSeed;
    num_pat     = 0;
    num_done    = 0;
    prev_stall  = 1'b0;
    for (int t = 0; t < NumTags; t++) begin
      pending[t] = 1'b0;
    end
    load_patterns();
    if (num_pat < 2) begin
      abort_run("The pattern file holds fewer than two operations");
    end

    repeat (8) @(posedge clk_i);
    @(negedge clk_i);
    rst_i = 1'b0;
    repeat (3) begin
      #SampleSkew;
      check_quiet();
      @(negedge clk_i);
    end

    // Flush a binary32 and a binary16 operation held in flight
    for (idx = 0; idx < 2; idx++) begin
      drive_operation(idx);
      do begin
        #SampleSkew;
        sample_output();
        acc = in_ready_o;
        @(negedge clk_i);
      end while (!acc);
      in_valid_i = 1'b0;
    end
    flush_i = 1'b1;
    #SampleSkew;
    check_value("busy_o", 32'(busy_o), 32'd1);
    sample_output();
    @(negedge clk_i);
    flush_i = 1'b0;
    #SampleSkew;
    check_value("busy_o", 32'(busy_o), 32'd0);
    check_value("out_valid_o", 32'(out_valid_o), 32'd0);
    sample_output();
    @(negedge clk_i);

    // Full pattern run with idle cycles and back-pressure
    idx = 0;
    while (num_done < num_pat) begin
      draw_bits(2, bits);
      out_ready_i = bits[0] | bits[1];
      if (!in_valid_i && idx < num_pat && !pending[pat_tag[idx]]) begin
        draw_bits(1, bits);
        if (!bits[0]) begin
          drive_operation(idx);
        end
      end
      #SampleSkew;
      sample_output();
      acc = in_valid_i && in_ready_o;
      if (acc) begin
        pending[pat_tag[idx]] = 1'b1;
        exp_res[pat_tag[idx]] = pat_res[idx];
        exp_sts[pat_tag[idx]] = pat_sts[idx];
        idx++;
      end
      @(negedge clk_i);
      if (acc) begin
        in_valid_i = 1'b0;
      end
    end
    out_ready_i = 1'b1;
    #SampleSkew;
    check_value("busy_o", 32'(busy_o), 32'd0);
    sample_output();

    $display("All tests passed");
    $finish;
  end

  // Watchdog allows 64 cycles per operation
  initial begin
    wait (num_pat > 0);
    repeat (num_pat * 64) @(posedge clk_i);
    abort_run("Watchdog expired before all operations completed");
  end

endmodule

// ==== hdl/fpu_noncomp_block.sv ====
`timescale 1ns/1ps

/* Non-computational FPU operation group: format dispatch to the binary32
   and binary16 slices, result arbitration and busy indication */

module fpu_noncomp_block #(
  parameter int unsigned TagWidth     = 4,
  parameter int unsigned Fp32PipeRegs = 2,
  parameter int unsigned Fp16PipeRegs = 1
) (
  input  logic                       clk_i,
  input  logic                       rst_i,
  input  logic                       flush_i,
  // Input handshake and operation
  input  logic                       in_valid_i,
  output logic                       in_ready_o,
  input  logic [1:0][31:0]           operands_i,
  input  fpu_op_pkg::operation_e     op_i,
  input  fpu_fmt_pkg::fp_format_e    fmt_i,
  input  logic [TagWidth-1:0]        tag_i,
  // Output handshake and result
  output logic                       out_valid_o,
  input  logic                       out_ready_i,
  output logic [31:0]                result_o,
  output fpu_op_pkg::status_t        status_o,
  output logic [TagWidth-1:0]        tag_o,
  output logic                       busy_o
);

  import fpu_fmt_pkg::*;

  logic [1:0] slice_in_valid;
  logic [1:0] slice_in_ready;
  logic [1:0] slice_busy;

  slice_out_if #(.TagWidth(TagWidth)) slice_out [2] ();

  // --------------------------------------------------------------------------
  // Format dispatch
  // --------------------------------------------------------------------------
  assign slice_in_valid[0] = in_valid_i & (fmt_i == FMT_FP32);
  assign slice_in_valid[1] = in_valid_i & (fmt_i == FMT_FP16);

  // Ready comes from the selected slice only
  assign in_ready_o = in_valid_i & slice_in_ready[fmt_i];

  // --------------------------------------------------------------------------
  // Format slices
  // --------------------------------------------------------------------------
  for (genvar f = 0; f < 2; f++) begin : gen_slice
    fpu_noncomp_slice #(
      .Format      (fp_format_e'(f)),
      .NumPipeRegs ((f == 0) ? Fp32PipeRegs : Fp16PipeRegs),
      .TagWidth    (TagWidth)
    ) i_slice (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .flush_i    (flush_i),
      .in_valid_i (slice_in_valid[f]),
      .operands_i (operands_i),
      .op_i       (op_i),
      .tag_i      (tag_i),
      .in_ready_o (slice_in_ready[f]),
      .busy_o     (slice_busy[f]),
      .out_o      (slice_out[f])
    );
  end

  // --------------------------------------------------------------------------
  // Result arbitration
  // --------------------------------------------------------------------------
  fpu_result_arbiter #(
    .TagWidth (TagWidth)
  ) i_arbiter (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .flush_i     (flush_i),
    .out_ready_i (out_ready_i),
    .slice0_i    (slice_out[0]),
    .slice1_i    (slice_out[1]),
    .out_valid_o (out_valid_o),
    .result_o    (result_o),
    .status_o    (status_o),
    .tag_o       (tag_o)
  );

  assign busy_o = |slice_busy;

endmodule

// ==== hdl/fpu_result_arbiter.sv ====
`timescale 1ns/1ps

/* Round-robin arbiter merging two slice result streams into one
   valid/ready output, with the grant locked under back-pressure */

module fpu_result_arbiter #(
  parameter int unsigned TagWidth = 4
) (
  input  logic                clk_i,
  input  logic                rst_i,
  input  logic                flush_i,
  input  logic                out_ready_i,
  slice_out_if.consumer       slice0_i,
  slice_out_if.consumer       slice1_i,
  output logic                out_valid_o,
  output logic [31:0]         result_o,
  output fpu_op_pkg::status_t status_o,
  output logic [TagWidth-1:0] tag_o
);

  logic [1:0] req;
  logic [1:0] gnt;
  logic       sel;
  logic       prio_q;
  logic       lock_q;
  logic       lock_idx_q;

  assign req = {slice1_i.valid, slice0_i.valid};

  // Locked grant before the round-robin priority
  always_comb begin
    if (lock_q) begin
      sel = lock_idx_q;
    end else if (req[0] && req[1]) begin
      sel = prio_q;
    end else begin
      sel = req[1];
    end
  end

  assign out_valid_o    = req[sel];
  assign gnt            = {out_valid_o & sel, out_valid_o & ~sel};
  assign slice0_i.ready = gnt[0] & out_ready_i;
  assign slice1_i.ready = gnt[1] & out_ready_i;

  assign result_o = sel ? slice1_i.result : slice0_i.result;
  assign status_o = sel ? slice1_i.status : slice0_i.status;
  assign tag_o    = sel ? slice1_i.tag    : slice0_i.tag;

  // --------------------------------------------------------------------------
  // Priority and lock state
  // --------------------------------------------------------------------------
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      prio_q     <= 1'b0;
      lock_q     <= 1'b0;
      lock_idx_q <= 1'b0;
    end else if (flush_i) begin
      lock_q <= 1'b0;
    end else if (out_valid_o && out_ready_i) begin
      // Other slice goes first next time
      prio_q <= ~sel;
      lock_q <= 1'b0;
    end else if (out_valid_o) begin
      lock_q     <= 1'b1;
      lock_idx_q <= sel;
    end
  end

  // Grant stays on a stalled result until it is taken
  a_grant_held : assert property (@(posedge clk_i) disable iff (rst_i)
    out_valid_o && !out_ready_i && !flush_i |=> out_valid_o && (gnt == $past(gnt)));

  // A slice left waiting wins the next grant
  a_round_robin : assert property (@(posedge clk_i) disable iff (rst_i)
    out_valid_o && out_ready_i && req[~sel] && !flush_i |=>
      out_valid_o && (sel != $past(sel)));

endmodule

// ==== hdl/fpu_noncomp_slice.sv ====
`timescale 1ns/1ps

/* One format slice of the non-computational group: operand decode,
   min/max, sign injection, comparisons and an elastic output pipeline */

module fpu_noncomp_slice #(
  parameter fpu_fmt_pkg::fp_format_e Format      = fpu_fmt_pkg::FMT_FP32,
  parameter int unsigned             NumPipeRegs = 1,
  parameter int unsigned             TagWidth    = 4
) (
  input  logic                   clk_i,
  input  logic                   rst_i,
  input  logic                   flush_i,
  input  logic                   in_valid_i,
  input  logic [1:0][31:0]       operands_i,
  input  fpu_op_pkg::operation_e op_i,
  input  logic [TagWidth-1:0]    tag_i,
  output logic                   in_ready_o,
  output logic                   busy_o,
  slice_out_if.producer          out_o
);

  import fpu_fmt_pkg::*;
  import fpu_op_pkg::*;

  // Exponent and mantissa bits together
  localparam int unsigned MagBits = (Format == FMT_FP32) ? 31 : 15;

  operand_u           opw     [2];
  logic               sgn     [2];
  logic [MagBits-1:0] mag     [2];
  logic               is_nan  [2];
  logic               is_snan [2];
  logic               is_zero [2];

  logic               res_sign;
  logic [MagBits-1:0] res_mag;
  logic [31:0]        res_word;
  logic [31:0]        canon_nan;
  logic [31:0]        calc_result;
  status_t            calc_status;

  assign opw[0] = operands_i[0];
  assign opw[1] = operands_i[1];

  // --------------------------------------------------------------------------
  // Operand decode
  // --------------------------------------------------------------------------
  if (Format == FMT_FP32) begin : gen_fp32
    always_comb begin
      for (int i = 0; i < 2; i++) begin
        sgn[i]     = opw[i].fp32.sign;
        mag[i]     = {opw[i].fp32.exponent, opw[i].fp32.mantissa};
        is_nan[i]  = (&opw[i].fp32.exponent) & (|opw[i].fp32.mantissa);
        is_snan[i] = is_nan[i] & ~opw[i].fp32.mantissa[22];
        is_zero[i] = ~(|mag[i]);
      end
    end
    assign res_word  = {res_sign, res_mag};
    assign canon_nan = CANON_NAN32;
  end else begin : gen_fp16
    fp16_t hv [2];
    always_comb begin
      for (int i = 0; i < 2; i++) begin
        // Broken box reads as canonical NaN
        hv[i]      = (opw[i].fp16.box == FP16_BOX) ? opw[i].fp16.val : CANON_NAN16;
        sgn[i]     = hv[i].sign;
        mag[i]     = {hv[i].exponent, hv[i].mantissa};
        is_nan[i]  = (&hv[i].exponent) & (|hv[i].mantissa);
        is_snan[i] = is_nan[i] & ~hv[i].mantissa[9];
        is_zero[i] = ~(|mag[i]);
      end
    end
    assign res_word  = {FP16_BOX, res_sign, res_mag};
    assign canon_nan = {FP16_BOX, CANON_NAN16};
  end

  // --------------------------------------------------------------------------
  // Operation logic
  // --------------------------------------------------------------------------
  always_comb begin
    logic lt_raw;
    logic eq_raw;
    logic both_zero;
    logic any_nan;
    logic any_snan;
    logic use_fp;
    logic use_canon;
    logic cmp_bit;
    logic nv;

    any_nan   = is_nan[0] | is_nan[1];
    any_snan  = is_snan[0] | is_snan[1];
    both_zero = is_zero[0] & is_zero[1];
    eq_raw    = (sgn[0] == sgn[1]) && (mag[0] == mag[1]);
    // Sign-magnitude order, -0 below +0
    if (sgn[0] != sgn[1]) begin
      lt_raw = sgn[0];
    end else begin
      lt_raw = sgn[0] ? (mag[0] > mag[1]) : (mag[0] < mag[1]);
    end

    res_sign  = sgn[0];
    res_mag   = mag[0];
    use_fp    = 1'b1;
    use_canon = 1'b0;
    cmp_bit   = 1'b0;
    nv        = 1'b0;

    unique case (op_i)
      OP_MIN, OP_MAX: begin
        nv = any_snan;
        if (is_nan[0] && is_nan[1]) begin
          use_canon = 1'b1;
        end else if (is_nan[0] || (!is_nan[1] && ((op_i == OP_MIN) ^ lt_raw))) begin
          res_sign = sgn[1];
          res_mag  = mag[1];
        end
      end
      OP_SGNJ:  res_sign = sgn[1];
      OP_SGNJN: res_sign = ~sgn[1];
      OP_SGNJX: res_sign = sgn[0] ^ sgn[1];
      OP_FEQ: begin
        use_fp  = 1'b0;
        nv      = any_snan;
        cmp_bit = ~any_nan & (eq_raw | both_zero);
      end
      OP_FLT: begin
        use_fp  = 1'b0;
        nv      = any_nan;
        cmp_bit = ~any_nan & lt_raw & ~both_zero;
      end
      OP_FLE: begin
        use_fp  = 1'b0;
        nv      = any_nan;
        cmp_bit = ~any_nan & ((lt_raw & ~both_zero) | eq_raw | both_zero);
      end
      default: ;
    endcase

    if (use_canon) begin
      calc_result = canon_nan;
    end else if (use_fp) begin
      calc_result = res_word;
    end else begin
      calc_result = {31'b0, cmp_bit};
    end
    calc_status    = '0;
    calc_status.nv = nv;
  end

  // --------------------------------------------------------------------------
  // Elastic pipeline, index 0 is the input side
  // --------------------------------------------------------------------------
  logic                stg_valid  [NumPipeRegs+1];
  logic                stg_ready  [NumPipeRegs+1];
  logic [31:0]         stg_result [NumPipeRegs+1];
  status_t             stg_status [NumPipeRegs+1];
  logic [TagWidth-1:0] stg_tag    [NumPipeRegs+1];

  assign stg_valid[0]  = in_valid_i;
  assign stg_result[0] = calc_result;
  assign stg_status[0] = calc_status;
  assign stg_tag[0]    = tag_i;
  assign in_ready_o    = stg_ready[0];

  for (genvar s = 0; s < NumPipeRegs; s++) begin : gen_stage
    // Free slot or the held item leaves this cycle
    assign stg_ready[s] = stg_ready[s+1] | ~stg_valid[s+1];

    always_ff @(posedge clk_i) begin
      if (rst_i || flush_i) begin
        stg_valid[s+1] <= 1'b0;
      end else if (stg_ready[s]) begin
        stg_valid[s+1] <= stg_valid[s];
      end
    end

    always_ff @(posedge clk_i) begin
      if (stg_valid[s] && stg_ready[s]) begin
        stg_result[s+1] <= stg_result[s];
        stg_status[s+1] <= stg_status[s];
        stg_tag[s+1]    <= stg_tag[s];
      end
    end
  end

  assign stg_ready[NumPipeRegs] = out_o.ready;
  assign out_o.valid            = stg_valid[NumPipeRegs];
  assign out_o.result           = stg_result[NumPipeRegs];
  assign out_o.status           = stg_status[NumPipeRegs];
  assign out_o.tag              = stg_tag[NumPipeRegs];

  always_comb begin
    busy_o = 1'b0;
    for (int s = 1; s <= NumPipeRegs; s++) begin
      busy_o = busy_o | stg_valid[s];
    end
  end

  // Stalled result must not change before the arbiter takes it
  a_out_stable : assert property (@(posedge clk_i) disable iff (rst_i || flush_i)
    out_o.valid && !out_o.ready |=> out_o.valid && $stable(out_o.result) &&
                                    $stable(out_o.status) && $stable(out_o.tag));

endmodule

// ==== hdl/slice_out_if.sv ====
`timescale 1ns/1ps

/* Result stream from one format slice to the result arbiter */

interface slice_out_if #(
  parameter int unsigned TagWidth = 4
);

  import fpu_op_pkg::*;

  logic                valid;
  logic                ready;
  logic [31:0]         result;
  status_t             status;
  logic [TagWidth-1:0] tag;

  // Slice side
  modport producer (output valid, result, status, tag, input ready);

  // Arbiter side
  modport consumer (input valid, result, status, tag, output ready);

endinterface

// ==== hdl/fpu_op_pkg.sv ====
/* Operation codes of the non-computational group and the
   IEEE 754 exception flag set */

package fpu_op_pkg;

  // --------------------------------------------------------------------------
  // Operations
  // --------------------------------------------------------------------------
  typedef enum logic [2:0] {
    OP_MIN   = 3'd0,
    OP_MAX   = 3'd1,
    OP_SGNJ  = 3'd2,
    OP_SGNJN = 3'd3,
    OP_SGNJX = 3'd4,
    OP_FEQ   = 3'd5,
    OP_FLT   = 3'd6,
    OP_FLE   = 3'd7
  } operation_e;

  // --------------------------------------------------------------------------
  // Exception flags
  // --------------------------------------------------------------------------
  // Invalid, divide by zero, overflow, underflow, inexact
  typedef struct packed {
    logic nv;
    logic dz;
    logic of;
    logic uf;
    logic nx;
  } status_t;

endpackage

// ==== hdl/fpu_fmt_pkg.sv ====
/* Floating-point format definitions for the non-computational group:
   format select, binary32 and binary16 bit layouts, the operand word
   union and canonical quiet NaN patterns */

package fpu_fmt_pkg;

  // --------------------------------------------------------------------------
  // Format select
  // --------------------------------------------------------------------------
  typedef enum logic {
    FMT_FP32 = 1'b0,
    FMT_FP16 = 1'b1
  } fp_format_e;

  // --------------------------------------------------------------------------
  // Bit layouts
  // --------------------------------------------------------------------------
  typedef struct packed {
    logic        sign;
    logic [7:0]  exponent;
    logic [22:0] mantissa;
  } fp32_t;

  typedef struct packed {
    logic       sign;
    logic [4:0] exponent;
    logic [9:0] mantissa;
  } fp16_t;

  // One 32-bit operand word, seen as binary32 or as a boxed binary16
  typedef union packed {
    fp32_t fp32;
    struct packed {
      logic [15:0] box;
      fp16_t       val;
    } fp16;
  } operand_u;

  // Upper half of a properly NaN-boxed binary16 word
  localparam logic [15:0] FP16_BOX = 16'hFFFF;

  // --------------------------------------------------------------------------
  // Canonical quiet NaNs
  // --------------------------------------------------------------------------
  localparam logic [31:0] CANON_NAN32 = 32'h7FC0_0000;
  localparam logic [15:0] CANON_NAN16 = 16'h7E00;

endpackage
